//--- Makefile
# Verilator simulation of the streaming read master

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module read_master_tb \
		--Mdir obj_dir -o read_master_sim
	./obj_dir/read_master_sim | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/read_master_properties.sv
// protocol assertions on the command, memory, stream and response ports of the read master
`timescale 1ns/1ps
`include "read_master_cfg.svh"

module read_master_properties
  import read_master_types_pkg::*;
  import read_master_ctrl_pkg::*;
(
  input logic        clk,
  input logic        reset_int,
  input logic        cmd_valid,
  input logic        cmd_ready,
  input logic        mem_read,
  input logic        mem_waitrequest,
  input addr_t       mem_address,
  input logic        st_valid,
  input logic        st_ready,
  input logic        st_eop,
  input empty_t      st_empty,
  input logic        resp_valid,
  input logic        resp_ready,
  input ctrl_state_t state          // the transfer FSM register
);

  int failures = 0;  // seen by the testbench
  int owed;          // reads accepted minus beats popped

  task automatic note_failure(string msg);
    failures = failures + 1;
    $error("%s", msg);
  endtask

  always_ff @(posedge clk or posedge reset_int)
  begin
    if (reset_int)
    begin
      owed <= 0;
    end
    else
    begin
      owed <= owed + int'(mem_read & ~mem_waitrequest) - int'(st_valid & st_ready);
    end
  end

  reset_idle: assert property (@(posedge clk)
    (reset_int || $fell(reset_int)) |-> cmd_ready && !mem_read && !st_valid && !resp_valid)
    else note_failure("outputs not idle in or right after reset");

  // a stalled read keeps its request and its address
  read_hold: assert property (@(posedge clk) disable iff (reset_int)
    mem_read && mem_waitrequest |=> mem_read && $stable(mem_address))
    else note_failure("mem_read or mem_address moved under waitrequest");

  fifo_room: assert property (@(posedge clk) disable iff (reset_int)
    owed >= 0 && owed <= `RM_FIFO_DEPTH)
    else note_failure("more reads outstanding than the FIFO can hold");

  go_drops_ready: assert property (@(posedge clk) disable iff (reset_int)
    cmd_valid && cmd_ready |=> !cmd_ready)
    else note_failure("cmd_ready still high after a command was taken");

  busy_holds: assert property (@(posedge clk) disable iff (reset_int)
    !cmd_ready && !(resp_valid && resp_ready) |=> !cmd_ready)
    else note_failure("cmd_ready rose before the response was popped");

  pop_frees: assert property (@(posedge clk) disable iff (reset_int)
    resp_valid && resp_ready |=> cmd_ready)
    else note_failure("cmd_ready did not return after the response pop");

  resp_holds: assert property (@(posedge clk) disable iff (reset_int)
    resp_valid && !resp_ready |=> resp_valid)
    else note_failure("resp_valid dropped before it was popped");

  empty_on_eop: assert property (@(posedge clk) disable iff (reset_int)
    st_valid && !st_eop |-> st_empty == '0)
    else note_failure("st_empty nonzero on a beat without eop");

  // reads go out only while the FSM is issuing, none trail into the drain
  read_in_issue: assert property (@(posedge clk) disable iff (reset_int)
    mem_read |-> state == ctrl_issue)
    else note_failure("mem_read high outside the issue state");

endmodule

//--- bench/read_master_tb.sv
// testbench for the streaming read master with random commands, a memory model and a stream scoreboard
`timescale 1ns/1ps
`include "read_master_cfg.svh"

module read_master_tb
  import read_master_types_pkg::*;
();

  localparam int NUM_CMDS = 12;
  // twelve commands of at most sixteen words, forty cycles allowed per word
  localparam int TIMEOUT_CYCLES = NUM_CMDS * 16 * 40;

  logic   clk;
  logic   reset_int;
  logic   cmd_valid = 1'b0;
  addr_t  cmd_address = '0;
  len_t   cmd_length = len_t'(1);
  logic   cmd_sop = 1'b0;
  logic   cmd_eop = 1'b0;
  logic   mem_waitrequest = 1'b0;
  word_t  mem_readdata = '0;
  logic   mem_readdatavalid = 1'b0;
  logic   st_ready = 1'b0;
  logic   resp_ready = 1'b0;
  logic   cmd_ready;
  addr_t  mem_address;
  logic   mem_read;
  logic   st_valid;
  word_t  st_data;
  logic   st_sop;
  logic   st_eop;
  empty_t st_empty;
  logic   resp_valid;

  logic [15:0] lfsr_state = 16'd19;
  int    cycle = 0;
  int    cmd_count = 0;      // commands taken by the DUT
  int    resp_pops = 0;
  int    total_words = 0;    // words owed by all commands taken so far
  int    total_reads = 0;
  int    total_returns = 0;
  int    gap_left = 0;       // idle cycles before the next command is offered
  int    stall_left = 0;     // remaining cycles of a long st_ready stall
  logic  cmd_taken = 1'b0;
  logic  all_done = 1'b0;
  addr_t exp_read_addr = '0;
  addr_t pend_addr_q[$];     // accepted reads waiting for their data
  int    pend_due_q[$];      // cycle on which each one may return
  word_t exp_data_q[$];
  logic [3:0] exp_mark_q[$]; // sop, eop and empty of each expected beat

  read_master_top dut_i (.*);

  bind read_master_top read_master_properties props_i (
    .clk             (clk),
    .reset_int       (reset_int),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .mem_read        (mem_read),
    .mem_waitrequest (mem_waitrequest),
    .mem_address     (mem_address),
    .st_valid        (st_valid),
    .st_ready        (st_ready),
    .st_eop          (st_eop),
    .st_empty        (st_empty),
    .resp_valid      (resp_valid),
    .resp_ready      (resp_ready),
    .state           (ctrl_fsm_i.state)
  );

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic take_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[15:1]} ^ (out ? 16'hB400 : 16'h0000);
    return out;
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  function automatic logic [7:0] byte_at(addr_t addr);
    return addr[7:0] ^ 8'h5A;  // memory content rule
  endfunction

  // the memory holds the lowest addressed byte in the low lane
  function automatic word_t mem_word(addr_t addr);
    word_t w;
    for (int i = 0; i < `RM_BYTES_PER_WORD; i++)
    begin
      w[8*i +: 8] = byte_at(addr + addr_t'(i));
    end
    return w;
  endfunction

  task automatic report_mismatch(string msg);
    $display("FAIL at %0t: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic present_command();
    cmd_valid   = 1'b1;
    cmd_address = addr_t'(take_bits(12));       // low bits random, the DUT drops them
    cmd_length  = len_t'(take_bits(6) + 32'd1); // 1 to 64 bytes
    cmd_sop     = take_bit();
    cmd_eop     = take_bit();
  endtask

  // the command goes in at the coming edge, so queue what it must produce
  task automatic expect_command();
    addr_t      base;
    int         words;
    int         tail;
    word_t      data;
    logic [3:0] mark;
    base       = cmd_address;
    base[1:0]  = 2'b00;  // start of the first word
    words = (int'(cmd_length) + 3) / 4;
    tail  = (4 - int'(cmd_length) % 4) % 4;
    for (int j = 0; j < words; j++)
    begin
      for (int k = 0; k < `RM_BYTES_PER_WORD; k++)
      begin
        data[31-8*k -: 8] = byte_at(base + addr_t'(4 * j + k)); // network order
      end
      mark[3]   = cmd_sop && (j == 0);
      mark[2]   = cmd_eop && (j == words - 1);
      mark[1:0] = mark[2] ? tail[1:0] : 2'b00;
      exp_data_q.push_back(data);
      exp_mark_q.push_back(mark);
    end
    exp_read_addr = base;
    total_words   = total_words + words;
  endtask

  task automatic check_beat();
    logic [3:0] mark;
    assert (exp_data_q.size() != 0)
      else report_mismatch("stream beat while no beat was expected");
    mark = {st_sop, st_eop, st_empty};
    assert (st_data == exp_data_q[0])
      else report_mismatch($sformatf("st_data %h, expected %h", st_data, exp_data_q[0]));
    assert (mark == exp_mark_q[0])
      else report_mismatch($sformatf("sop/eop/empty %b, expected %b", mark, exp_mark_q[0]));
    exp_data_q.delete(0);
    exp_mark_q.delete(0);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  initial
  begin
    reset_int = 1'b1;
    repeat (16) @(negedge clk);
    reset_int = 1'b0;
    wait (all_done);
    @(negedge clk);  // give the bound checker one more edge
    if (dut_i.props_i.failures == 0)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
    begin
      $display("a bound protocol assertion failed");
      $display("Result: FAILED");
      $fatal(1);
    end
  end

  // all inputs move on the falling edge, where every DUT output is settled
  always @(negedge clk)
  begin
    cycle = cycle + 1;
    if (cycle > TIMEOUT_CYCLES)
    begin
      $display("timeout, transfers still open after %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $fatal(1);
    end
    if (dut_i.props_i.failures != 0)
    begin
      $display("a bound protocol assertion failed");
      $display("Result: FAILED");
      $fatal(1);
    end
    if (cycle <= 17)  // through reset and the first cycle after it
      assert (cmd_ready && !mem_read && !st_valid && !resp_valid)
        else report_mismatch("outputs not at their reset values");

    // a response may only follow the last returned word
    if (resp_valid)
      assert (total_returns == total_words)
        else report_mismatch($sformatf("response after %0d of %0d words",
                                       total_returns, total_words));
    resp_ready = take_bit() & take_bit();  // random pop delay
    if (resp_valid && resp_ready)
      resp_pops = resp_pops + 1;

    // in-order returns once the latency of the head read has passed
    if (pend_addr_q.size() != 0 && pend_due_q[0] <= cycle)
    begin
      mem_readdatavalid = 1'b1;
      mem_readdata      = mem_word(pend_addr_q.pop_front());
      pend_due_q.delete(0);
      total_returns     = total_returns + 1;
    end
    else
    begin
      mem_readdatavalid = 1'b0;
      mem_readdata      = '0;
    end

    mem_waitrequest = (take_bits(2) == 32'd0);  // stalls about one cycle in four
    if (mem_read && !mem_waitrequest)
    begin
      assert (mem_address == exp_read_addr && total_reads < total_words)
        else report_mismatch($sformatf("read of %h accepted, expected %h",
                                       mem_address, exp_read_addr));
      pend_addr_q.push_back(mem_address);
      pend_due_q.push_back(cycle + int'(take_bits(2)) + 1);  // 1 to 4 cycles
      exp_read_addr = exp_read_addr + addr_t'(`RM_BYTES_PER_WORD);
      total_reads   = total_reads + 1;
    end

    // long stalls fill the FIFO so the credits run out
    if (stall_left != 0)
    begin
      st_ready   = 1'b0;
      stall_left = stall_left - 1;
    end
    else if (take_bits(3) == 32'd0)
    begin
      st_ready   = 1'b0;
      stall_left = 8 + int'(take_bits(5));
    end
    else
      st_ready = take_bit() | take_bit();
    if (st_valid && st_ready)
      check_beat();

    if (cmd_taken)
    begin
      cmd_valid = 1'b0;
      cmd_taken = 1'b0;
      gap_left  = int'(take_bits(2));
    end
    // with no gap the next command waits on cmd_ready while the DUT is busy
    if (!cmd_valid && cmd_count < NUM_CMDS && cycle > 17)
    begin
      if (gap_left != 0)
        gap_left = gap_left - 1;
      else
        present_command();
    end
    if (cmd_valid && cmd_ready)
    begin
      expect_command();
      cmd_taken = 1'b1;
      cmd_count = cmd_count + 1;
    end

    all_done = (resp_pops == NUM_CMDS) && (exp_data_q.size() == 0);
  end

endmodule

//--- filelist.f
+incdir+rtl
rtl/read_master_types_pkg.sv
rtl/read_master_ctrl_pkg.sv
rtl/read_ctrl_fsm.sv
rtl/read_credit_counter.sv
rtl/read_addr_gen.sv
rtl/read_stream_fifo.sv
rtl/read_master_top.sv
bench/read_master_properties.sv
bench/read_master_tb.sv

//--- rtl/read_addr_gen.sv
// address and remaining-length counters that drive single-word reads on the memory port
`timescale 1ns/1ps
`include "read_master_cfg.svh"

module read_addr_gen
  import read_master_types_pkg::*;
(
  input  logic  clk,
  input  logic  reset_int,
  input  logic  go,               // load a new command
  input  logic  issue_en,         // FSM is in its issue state
  input  logic  issue_ok,         // enough credits for another read
  input  logic  mem_waitrequest,
  input  addr_t cmd_address,
  input  len_t  cmd_length,
  output addr_t mem_address,
  output logic  mem_read,
  output logic  read_accepted,
  output logic  all_issued
);

  addr_t addr_cnt;   // word address of the next read
  len_t  len_cnt;    // bytes still to be requested
  len_t  step_len;   // bytes covered by the current read
  len_t  len_next;   // remaining length once the current read is taken

  // a full word unless only a tail is left
  assign step_len = (len_cnt < len_t'(`RM_BYTES_PER_WORD)) ? len_cnt :
                    len_t'(`RM_BYTES_PER_WORD);
  assign len_next = len_cnt - step_len;

  assign read_accepted = mem_read & ~mem_waitrequest;
  assign all_issued    = (len_cnt == '0);
  assign mem_address   = addr_cnt;  // already word aligned by the load

  always_ff @(posedge clk or posedge reset_int)
  begin
    if (reset_int)
    begin
      addr_cnt <= '0;
      len_cnt  <= '0;
    end
    else if (go)
    begin
      // the byte offset bits are ignored, every transfer starts on a word
      addr_cnt <= cmd_address & ~addr_t'(`RM_BYTES_PER_WORD - 1);
      len_cnt  <= cmd_length;
    end
    else if (read_accepted)
    begin
      addr_cnt <= addr_cnt + addr_t'(`RM_BYTES_PER_WORD);
      len_cnt  <= len_next;
    end
  end

  // registered read request
  // while waitrequest stalls an issued read, the request and the address hold
  always_ff @(posedge clk or posedge reset_int)
  begin
    if (reset_int)
    begin
      mem_read <= 1'b0;
    end
    else if (read_accepted)
    begin
      // keep reading back to back unless this was the last read or credits ran low
      mem_read <= issue_en & issue_ok & (len_next != '0);
    end
    else if (!mem_read)
    begin
      mem_read <= issue_en & issue_ok & (len_cnt != '0);
    end
  end

endmodule

//--- rtl/read_credit_counter.sv
// credit and in-flight counters that hold back reads until the return FIFO has room
`timescale 1ns/1ps
`include "read_master_cfg.svh"

module read_credit_counter
  import read_master_types_pkg::*;
(
  input  logic clk,
  input  logic reset_int,
  input  logic read_accepted,      // mem_read taken by the memory this cycle
  input  logic mem_readdatavalid,  // a word came back this cycle
  input  logic beat_popped,        // a word left the FIFO on the stream
  output logic issue_ok,
  output logic in_flight_zero
);

  // FIFO words that are neither filled nor promised to an outstanding read
  credit_t credits;

  // reads accepted by the memory whose data has not yet returned
  credit_t in_flight;

  // an accepted read claims a word, a popped beat gives one back
  // both on the same cycle leave the count unchanged
  always_ff @(posedge clk or posedge reset_int)
  begin
    if (reset_int)
    begin
      credits <= credit_t'(`RM_FIFO_DEPTH);  // the whole FIFO is free after reset
    end
    else
    begin
      credits <= credits - credit_t'(read_accepted) + credit_t'(beat_popped);
    end
  end

  // the credit count can never let more reads out than the FIFO holds,
  // so this count also stays within the depth
  always_ff @(posedge clk or posedge reset_int)
  begin
    if (reset_int)
    begin
      in_flight <= '0;
    end
    else
    begin
      in_flight <= in_flight + credit_t'(read_accepted) - credit_t'(mem_readdatavalid);
    end
  end

  // the count lags its events by a clock and mem_read lags issue_ok by
  // another, hence the margin instead of a plain nonzero test
  assign issue_ok = (credits > credit_t'(`RM_CREDIT_MARGIN));

  assign in_flight_zero = (in_flight == '0);  // used by the FSM to end the drain

endmodule

//--- rtl/read_ctrl_fsm.sv
// transfer FSM that takes a command, sequences read issue and drain, and posts the response
`timescale 1ns/1ps

module read_ctrl_fsm
  import read_master_ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset_int,
  input  logic cmd_valid,
  input  logic all_issued,      // remaining length has reached zero
  input  logic in_flight_zero,  // no read is waiting for its data
  input  logic resp_ready,
  output logic cmd_ready,
  output logic go,
  output logic issue_en,
  output logic resp_valid
);

  ctrl_state_t state;
  ctrl_state_t state_next;

  // all outputs are decoded straight from the state register
  assign cmd_ready  = (state == ctrl_idle);     // high out of reset
  assign go         = cmd_valid & cmd_ready;    // lasts one cycle since the state moves on
  assign issue_en   = (state == ctrl_issue);
  assign resp_valid = (state == ctrl_respond);  // held until the pop

  always_comb
  begin
    state_next = state;  // stay by default
    unique case (state)
      ctrl_idle:
      begin
        if (go)
        begin
          state_next = ctrl_issue;
        end
      end
      ctrl_issue:
      begin
        // the address generator loaded a nonzero length on go, so this
        // only fires once the last read has been accepted
        if (all_issued)
        begin
          state_next = ctrl_drain;
        end
      end
      ctrl_drain:
      begin
        // the in-flight count trails readdatavalid by a cycle, so the
        // response can never get ahead of the last returned word
        if (in_flight_zero)
        begin
          state_next = ctrl_respond;
        end
      end
      ctrl_respond:
      begin
        if (resp_ready)
        begin
          state_next = ctrl_idle;  // popped, cmd_ready comes back next cycle
        end
      end
      default:
      begin
        state_next = ctrl_idle;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset_int)
  begin
    if (reset_int)
    begin
      state <= ctrl_idle;
    end
    else
    begin
      state <= state_next;
    end
  end

endmodule

//--- rtl/read_master_cfg.svh
// read master configuration: bus widths, return FIFO depth and read credit margin
`ifndef READ_MASTER_CFG_SVH
`define READ_MASTER_CFG_SVH

// memory port and descriptor widths
`define RM_ADDR_WIDTH 32      // byte address into the memory map
`define RM_LEN_WIDTH 16       // transfer length in bytes, so up to 64 KiB per command

// one memory word is one stream beat
`define RM_DATA_WIDTH 32
`define RM_SYMBOL_WIDTH 8     // stream symbols are bytes
`define RM_BYTES_PER_WORD 4
`define RM_BYTE_ADDR_BITS 2   // log2 of the bytes per word, also the width of st_empty

// return buffer between the read port and the stream
`define RM_FIFO_DEPTH 16
`define RM_FIFO_DEPTH_LOG2 4

// mem_read is registered, so one more read can go out before the credit count
// catches up; two spare credits keep the FIFO from ever overflowing
`define RM_CREDIT_MARGIN 2

`endif

//--- rtl/read_master_ctrl_pkg.sv
// read master control types: states of the transfer FSM
package read_master_ctrl_pkg;

  // one command is handled at a time
  typedef enum logic [1:0] {
    ctrl_idle,     // waiting for a command, cmd_ready is high
    ctrl_issue,    // reads are being posted to the memory port
    ctrl_drain,    // every read posted, waiting for the data to come back
    ctrl_respond   // response offered until it is popped
  } ctrl_state_t;

endpackage

//--- rtl/read_master_top.sv
// streaming read master top level joining the control FSM, credit counter, address generator and FIFO
`timescale 1ns/1ps

module read_master_top
  import read_master_types_pkg::*;
(
  input  logic   clk,
  input  logic   reset_int,
  // command
  input  logic   cmd_valid,
  output logic   cmd_ready,
  input  addr_t  cmd_address,
  input  len_t   cmd_length,   // must not be zero
  input  logic   cmd_sop,
  input  logic   cmd_eop,
  // memory read port
  output addr_t  mem_address,
  output logic   mem_read,
  input  logic   mem_waitrequest,
  input  word_t  mem_readdata,
  input  logic   mem_readdatavalid,
  // stream source
  output logic   st_valid,
  input  logic   st_ready,
  output word_t  st_data,
  output logic   st_sop,
  output logic   st_eop,
  output empty_t st_empty,
  // response, no payload
  output logic   resp_valid,
  input  logic   resp_ready
);

  logic go;              // command taken this cycle
  logic issue_en;
  logic read_accepted;
  logic all_issued;
  logic issue_ok;
  logic in_flight_zero;
  logic beat_popped;

  read_ctrl_fsm ctrl_fsm_i (
    .clk            (clk),
    .reset_int      (reset_int),
    .cmd_valid      (cmd_valid),
    .all_issued     (all_issued),
    .in_flight_zero (in_flight_zero),
    .resp_ready     (resp_ready),
    .cmd_ready      (cmd_ready),
    .go             (go),
    .issue_en       (issue_en),
    .resp_valid     (resp_valid)
  );

  // throttles the address generator against free space in the FIFO
  read_credit_counter credit_counter_i (
    .clk               (clk),
    .reset_int         (reset_int),
    .read_accepted     (read_accepted),
    .mem_readdatavalid (mem_readdatavalid),
    .beat_popped       (beat_popped),
    .issue_ok          (issue_ok),
    .in_flight_zero    (in_flight_zero)
  );

  read_addr_gen addr_gen_i (
    .clk             (clk),
    .reset_int       (reset_int),
    .go              (go),
    .issue_en        (issue_en),
    .issue_ok        (issue_ok),
    .mem_waitrequest (mem_waitrequest),
    .cmd_address     (cmd_address),
    .cmd_length      (cmd_length),
    .mem_address     (mem_address),
    .mem_read        (mem_read),
    .read_accepted   (read_accepted),
    .all_issued      (all_issued)
  );

  read_stream_fifo stream_fifo_i (
    .clk               (clk),
    .reset_int         (reset_int),
    .go                (go),
    .cmd_sop           (cmd_sop),
    .cmd_eop           (cmd_eop),
    .mem_readdatavalid (mem_readdatavalid),
    .st_ready          (st_ready),
    .cmd_length        (cmd_length),
    .mem_readdata      (mem_readdata),
    .st_data           (st_data),
    .st_empty          (st_empty),
    .st_valid          (st_valid),
    .st_sop            (st_sop),
    .st_eop            (st_eop),
    .beat_popped       (beat_popped)
  );

endmodule

//--- rtl/read_master_types_pkg.sv
// read master data types: addresses, byte lengths, data words, empty counts and credits
`include "read_master_cfg.svh"

package read_master_types_pkg;

  // byte address on the memory side, the low bits are dropped before use
  typedef logic [`RM_ADDR_WIDTH-1:0] addr_t;

  // count of bytes still to read, also used for the word count on the return path
  typedef logic [`RM_LEN_WIDTH-1:0] len_t;

  // one memory word, which is also one stream beat
  typedef logic [`RM_DATA_WIDTH-1:0] word_t;

  // unused symbols in the final beat of a packet
  typedef logic [`RM_BYTE_ADDR_BITS-1:0] empty_t;

  // a number of FIFO words from zero up to the full depth
  // one bit wider than the pointer so the full count fits
  typedef logic [`RM_FIFO_DEPTH_LOG2:0] credit_t;

endpackage

//--- rtl/read_stream_fifo.sv
// return path that tags words with sop, eop and empty, buffers them and drives the stream
`timescale 1ns/1ps
`include "read_master_cfg.svh"

module read_stream_fifo
  import read_master_types_pkg::*;
(
  input  logic   clk,
  input  logic   reset_int,
  input  logic   go,
  input  logic   cmd_sop,            // put sop on the first beat
  input  logic   cmd_eop,            // put eop and empty on the last beat
  input  logic   mem_readdatavalid,
  input  logic   st_ready,
  input  len_t   cmd_length,
  input  word_t  mem_readdata,
  output word_t  st_data,
  output empty_t st_empty,
  output logic   st_valid,
  output logic   st_sop,
  output logic   st_eop,
  output logic   beat_popped
);

  logic   sop_req;       // packet flags of the current command
  logic   eop_req;
  empty_t tail_empty;    // empty count for the final beat
  len_t   words_left;    // words still to come back from memory
  logic   first_word;    // next returned word opens the transfer
  len_t   cmd_words;
  len_t   tail_len;
  logic   tag_sop;
  logic   tag_eop;
  empty_t tag_empty;

  // return buffer, one entry per memory word
  word_t  data_mem [`RM_FIFO_DEPTH];
  logic   sop_mem [`RM_FIFO_DEPTH];
  logic   eop_mem [`RM_FIFO_DEPTH];
  empty_t empty_mem [`RM_FIFO_DEPTH];
  logic [`RM_FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [`RM_FIFO_DEPTH_LOG2-1:0] rd_ptr;
  credit_t fill_count;   // words held, never above the depth thanks to the credits
  word_t   rd_word;

  // words per command rounded up, a partial tail still costs a full read
  assign cmd_words = len_t'(cmd_length >> `RM_BYTE_ADDR_BITS) +
                     len_t'(|cmd_length[`RM_BYTE_ADDR_BITS-1:0]);
  // the low bits of word size minus length give the unused tail symbols,
  // zero when the length is a whole number of words
  assign tail_len = len_t'(`RM_BYTES_PER_WORD) - cmd_length;

  always_ff @(posedge clk)
  begin
    if (go)
    begin
      sop_req    <= cmd_sop;
      eop_req    <= cmd_eop;
      tail_empty <= tail_len[`RM_BYTE_ADDR_BITS-1:0];
    end
  end

  always_ff @(posedge clk or posedge reset_int)
  begin
    if (reset_int)
    begin
      words_left <= '0;
      first_word <= 1'b0;
    end
    else if (go)
    begin
      words_left <= cmd_words;
      first_word <= 1'b1;
    end
    else if (mem_readdatavalid)
    begin
      words_left <= words_left - len_t'(1);
      first_word <= 1'b0;
    end
  end

  // tag the word being written, empty is only meaningful next to eop
  assign tag_sop   = first_word & sop_req;
  assign tag_eop   = (words_left == len_t'(1)) & eop_req;
  assign tag_empty = tag_eop ? tail_empty : '0;

  always_ff @(posedge clk)
  begin
    if (mem_readdatavalid)
    begin
      data_mem[wr_ptr]  <= mem_readdata;
      sop_mem[wr_ptr]   <= tag_sop;
      eop_mem[wr_ptr]   <= tag_eop;
      empty_mem[wr_ptr] <= tag_empty;
    end
  end

  always_ff @(posedge clk or posedge reset_int)
  begin
    if (reset_int)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_count <= '0;
    end
    else
    begin
      wr_ptr     <= wr_ptr + (`RM_FIFO_DEPTH_LOG2)'(mem_readdatavalid);
      rd_ptr     <= rd_ptr + (`RM_FIFO_DEPTH_LOG2)'(beat_popped);
      fill_count <= fill_count + credit_t'(mem_readdatavalid) - credit_t'(beat_popped);
    end
  end

  // show-ahead: the head entry sits on the outputs as soon as the count says so
  assign st_valid    = (fill_count != '0);
  assign beat_popped = st_valid & st_ready;
  assign rd_word     = data_mem[rd_ptr];
  assign st_sop      = sop_mem[rd_ptr];
  assign st_eop      = eop_mem[rd_ptr];
  assign st_empty    = empty_mem[rd_ptr];

  // the lowest addressed byte is the least significant one in memory,
  // the stream wants it in the top symbol
  always_comb
  begin
    for (int i = 0; i < `RM_BYTES_PER_WORD; i++)
    begin
      st_data[i*`RM_SYMBOL_WIDTH +: `RM_SYMBOL_WIDTH] =
        rd_word[(`RM_BYTES_PER_WORD-1-i)*`RM_SYMBOL_WIDTH +: `RM_SYMBOL_WIDTH];
    end
  end

endmodule
